// ==== Makefile ====
# Verilator flow for the store queue testbench
# make compile builds, make run simulates and checks the log, make clean tidies up

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module store_queue_tb \
		-f store_queue.f -o store_queue_tb

run: compile
	./obj_dir/store_queue_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	fi; \
	echo "RESULT: PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/core_pkg.sv ====
//////////////////////////////////////////////////
// core-wide types shared across the store queue
// thread id, ROB index and the 64-bit data word
// imported by every block that needs these types
//////////////////////////////////////////////////

`default_nettype none

package core_pkg;

	// two hardware threads, one bit
	typedef enum logic [0:0] {
		thread_0 = 1'b0,
		thread_1 = 1'b1
	} thread_id_t;

	localparam int rob_idx_width = 5;   // 32 ROB entries

	typedef logic [rob_idx_width-1:0] rob_idx_t;

	// address or data word
	typedef logic [63:0] word_t;

endpackage : core_pkg

`default_nettype wire

// ==== hdl/lsq_pkg.sv ====
//////////////////////////////////////////////////
// store queue types: dispatch packet, per-thread
// allocation, queue entry, commit port and the
// memory write strobe
// compile after core_pkg
//////////////////////////////////////////////////

`default_nettype none

package lsq_pkg;

	// one dispatch slot, operands already resolved
	typedef struct packed {
		logic                  valid;
		core_pkg::thread_id_t  thread;
		core_pkg::word_t       base;
		core_pkg::word_t       offset;
		core_pkg::word_t       data;
		core_pkg::rob_idx_t    rob_idx;
	} store_dispatch_t;

	// store handed to one thread queue, address formed
	typedef struct packed {
		logic                  valid;
		core_pkg::word_t       addr;
		core_pkg::word_t       data;
		core_pkg::rob_idx_t    rob_idx;
	} store_alloc_t;

	typedef enum logic [1:0] {
		entry_free      = 2'd0,
		entry_pending   = 2'd1,   // waiting for ROB commit
		entry_committed = 2'd2    // waiting to drain
	} entry_state_t;

	typedef struct packed {
		entry_state_t          state;
		core_pkg::word_t       addr;
		core_pkg::word_t       data;
		core_pkg::rob_idx_t    rob_idx;
	} store_entry_t;

	typedef struct packed {
		logic                  valid;
		core_pkg::thread_id_t  thread;
		core_pkg::rob_idx_t    rob_idx;
	} commit_port_t;

	typedef struct packed {
		logic                  valid;
		core_pkg::word_t       addr;
		core_pkg::word_t       data;
	} mem_write_t;

endpackage : lsq_pkg

`default_nettype wire

// ==== hdl/store_dispatch.sv ====
//////////////////////////////////////////////////
// dispatch front end of the store queue
// adds base and offset for both slots and packs
// each thread's stores, in slot order, onto that
// thread's allocation pair
//////////////////////////////////////////////////

`default_nettype none

module store_dispatch (
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire lsq_pkg::store_dispatch_t [1:0] dispatch,   // slot 0 is older
	input  wire logic [1:0]                    mispredict,
	input  wire logic [1:0]                    full,         // per-thread queue full
	output lsq_pkg::store_alloc_t [1:0]        alloc_t0,
	output lsq_pkg::store_alloc_t [1:0]        alloc_t1
);

	import core_pkg::*;
	import lsq_pkg::*;

	store_alloc_t [1:0] slot;          // both slots with address formed
	store_alloc_t [1:0] alloc_q [2];   // per-thread packed pair
	logic [1:0]         keep [2];      // slot goes to this thread

	// effective address
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			slot[s].valid   = dispatch[s].valid;
			slot[s].addr    = dispatch[s].base + dispatch[s].offset;
			slot[s].data    = dispatch[s].data;
			slot[s].rob_idx = dispatch[s].rob_idx;
		end
	end

	//////////////////////////////////////////////////
	// steering
	//////////////////////////////////////////////////

	always_comb begin
		for (int t = 0; t < 2; t++) begin
			for (int s = 0; s < 2; s++) begin
				// a store racing its own thread's flush is lost
				keep[t][s] = dispatch[s].valid && !mispredict[t] &&
					(dispatch[s].thread == thread_id_t'(t));
			end

			// lowest kept slot lands in position 0
			if (keep[t][0])
				alloc_q[t][0] = slot[0];
			else if (keep[t][1])
				alloc_q[t][0] = slot[1];
			else
				alloc_q[t][0] = '0;

			alloc_q[t][1] = (keep[t][0] && keep[t][1]) ? slot[1] : '0;
		end
	end

	assign alloc_t0 = alloc_q[0];
	assign alloc_t1 = alloc_q[1];

	// upstream must respect the level full flag of the target thread
	for (genvar s = 0; s < 2; s++) begin : g_full_chk
		a_no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
			dispatch[s].valid |-> !full[dispatch[s].thread]);
	end

endmodule : store_dispatch

`default_nettype wire

// ==== hdl/store_drain_arbiter.sv ====
//////////////////////////////////////////////////
// memory drain arbiter
// one committed store per cycle, thread 0 wins,
// the chosen store is registered onto mem_write
// as a single-cycle strobe
//////////////////////////////////////////////////

`default_nettype none

module store_drain_arbiter (
	input  wire logic                      clock,
	input  wire logic                      reset,
	input  wire logic [1:0]                drain_ready,
	input  wire lsq_pkg::mem_write_t [1:0] drain_store,
	output logic [1:0]                     drain_grant,
	output lsq_pkg::mem_write_t            mem_write
);

	// fixed priority
	assign drain_grant[0] = drain_ready[0];
	assign drain_grant[1] = drain_ready[1] & ~drain_ready[0];

	//////////////////////////////////////////////////
	// write register
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_write.valid <= 1'b0;
		end else begin
			mem_write.valid <= |drain_grant;   // high for one cycle per grant
			if (drain_grant[0]) begin
				mem_write.addr <= drain_store[0].addr;
				mem_write.data <= drain_store[0].data;
			end else if (drain_grant[1]) begin
				mem_write.addr <= drain_store[1].addr;
				mem_write.data <= drain_store[1].data;
			end
		end
	end

	a_one_grant: assert property (@(posedge clock) disable iff (reset)
		$onehot0(drain_grant));

	// a grant must land on a store the queue actually offers
	for (genvar t = 0; t < 2; t++) begin : g_grant_chk
		a_grant_has_store: assert property (@(posedge clock) disable iff (reset)
			drain_grant[t] |-> drain_store[t].valid);
	end

endmodule : store_drain_arbiter

`default_nettype wire

// ==== hdl/store_queue_top.sv ====
//////////////////////////////////////////////////
// store queue top for the two-thread core
// dispatch steering, one queue per thread and the
// memory drain arbiter; sq_depth sets queue size
//////////////////////////////////////////////////

`default_nettype none

module store_queue_top #(
	parameter int sq_depth = 8
) (
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire lsq_pkg::store_dispatch_t [1:0] dispatch,
	input  wire lsq_pkg::commit_port_t [1:0]    commit,
	input  wire logic [1:0]                    mispredict,
	output logic [1:0]                         full,
	output logic [1:0]                         commit_done,
	output lsq_pkg::mem_write_t                mem_write
);

	import core_pkg::*;
	import lsq_pkg::*;

	store_alloc_t [1:0] alloc_t0, alloc_t1;
	mem_write_t         store_t0, store_t1;
	logic               ready_t0, ready_t1;
	logic               full_t0, full_t1;
	logic [1:0]         done_t0, done_t1;
	logic [1:0]         drain_grant;

	store_dispatch u_dispatch (
		.clock      (clock),
		.reset      (reset),
		.dispatch   (dispatch),
		.mispredict (mispredict),
		.full       (full),
		.alloc_t0   (alloc_t0),
		.alloc_t1   (alloc_t1)
	);

	thread_store_queue #(.sq_depth(sq_depth)) u_queue_t0 (
		.clock       (clock),
		.reset       (reset),
		.mispredict  (mispredict[0]),
		.my_thread   (thread_0),
		.alloc       (alloc_t0),
		.commit      (commit),
		.drain_grant (drain_grant[0]),
		.drain_ready (ready_t0),
		.drain_store (store_t0),
		.commit_done (done_t0),
		.full        (full_t0)
	);

	thread_store_queue #(.sq_depth(sq_depth)) u_queue_t1 (
		.clock       (clock),
		.reset       (reset),
		.mispredict  (mispredict[1]),
		.my_thread   (thread_1),
		.alloc       (alloc_t1),
		.commit      (commit),
		.drain_grant (drain_grant[1]),
		.drain_ready (ready_t1),
		.drain_store (store_t1),
		.commit_done (done_t1),
		.full        (full_t1)
	);

	store_drain_arbiter u_arbiter (
		.clock       (clock),
		.reset       (reset),
		.drain_ready ({ready_t1, ready_t0}),
		.drain_store ({store_t1, store_t0}),
		.drain_grant (drain_grant),
		.mem_write   (mem_write)
	);

	assign full        = {full_t1, full_t0};
	assign commit_done = done_t0 | done_t1;   // only the port's own thread can match

endmodule : store_queue_top

`default_nettype wire

// ==== hdl/thread_store_queue.sv ====
//////////////////////////////////////////////////
// circular store queue for one thread
// tail allocates, commit pointer follows the ROB,
// head drains committed stores toward memory
// instantiate once per thread, my_thread tied off
//////////////////////////////////////////////////

`default_nettype none

module thread_store_queue #(
	parameter int sq_depth = 8   // power of two
) (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       mispredict,
	input  wire core_pkg::thread_id_t       my_thread,
	input  wire lsq_pkg::store_alloc_t [1:0] alloc,
	input  wire lsq_pkg::commit_port_t [1:0] commit,
	input  wire logic                       drain_grant,
	output logic                            drain_ready,
	output lsq_pkg::mem_write_t             drain_store,
	output logic [1:0]                      commit_done,
	output logic                            full
);

	import lsq_pkg::*;

	localparam int idx_w = $clog2(sq_depth);

	typedef logic [idx_w:0] ptr_t;   // top bit is the wrap flag

	localparam ptr_t full_level = ptr_t'(sq_depth - 2);

	store_entry_t entries [sq_depth];
	store_entry_t entries_next [sq_depth];

	ptr_t tail, cmt, head;
	ptr_t tail_next, cmt_next, head_next;
	ptr_t cmt_second;        // where port 1 looks
	ptr_t used;

	store_entry_t cmt_entry, second_entry, head_entry;
	logic [1:0]   match;

	//////////////////////////////////////////////////
	// commit matching
	//////////////////////////////////////////////////

	assign cmt_entry = entries[cmt[idx_w-1:0]];

	assign match[0] = commit[0].valid && (commit[0].thread == my_thread) &&
		(cmt_entry.state == entry_pending) && (cmt_entry.rob_idx == commit[0].rob_idx);

	// port 1 sees the next entry once port 0 took the oldest
	assign cmt_second   = match[0] ? cmt + ptr_t'(1) : cmt;
	assign second_entry = entries[cmt_second[idx_w-1:0]];

	assign match[1] = commit[1].valid && (commit[1].thread == my_thread) &&
		(second_entry.state == entry_pending) &&
		(second_entry.rob_idx == commit[1].rob_idx);

	assign commit_done = match;
	assign cmt_next    = cmt + ptr_t'(match[0]) + ptr_t'(match[1]);

	// drain side
	assign head_entry        = entries[head[idx_w-1:0]];
	assign drain_ready       = (head_entry.state == entry_committed);
	assign drain_store.valid = drain_ready;
	assign drain_store.addr  = head_entry.addr;
	assign drain_store.data  = head_entry.data;
	assign head_next         = head + ptr_t'(drain_grant);

	// flush rewinds tail to the post-commit pointer
	assign tail_next = mispredict ? cmt_next :
		tail + ptr_t'(alloc[0].valid) + ptr_t'(alloc[1].valid);

	// fewer than two free slots
	assign used = tail - head;
	assign full = (used > full_level);

	//////////////////////////////////////////////////
	// entry update
	//////////////////////////////////////////////////

	always_comb begin
		entries_next = entries;

		if (alloc[0].valid) begin
			entries_next[tail[idx_w-1:0]].state   = entry_pending;
			entries_next[tail[idx_w-1:0]].addr    = alloc[0].addr;
			entries_next[tail[idx_w-1:0]].data    = alloc[0].data;
			entries_next[tail[idx_w-1:0]].rob_idx = alloc[0].rob_idx;
		end
		if (alloc[1].valid) begin   // only set together with slot 0
			entries_next[idx_w'(tail + ptr_t'(1))].state   = entry_pending;
			entries_next[idx_w'(tail + ptr_t'(1))].addr    = alloc[1].addr;
			entries_next[idx_w'(tail + ptr_t'(1))].data    = alloc[1].data;
			entries_next[idx_w'(tail + ptr_t'(1))].rob_idx = alloc[1].rob_idx;
		end

		if (match[0])
			entries_next[cmt[idx_w-1:0]].state = entry_committed;
		if (match[1])
			entries_next[cmt_second[idx_w-1:0]].state = entry_committed;

		// wrong-path stores vanish, committed ones stay
		if (mispredict) begin
			for (int i = 0; i < sq_depth; i++) begin
				if (entries_next[i].state == entry_pending)
					entries_next[i].state = entry_free;
			end
		end

		if (drain_grant)
			entries_next[head[idx_w-1:0]].state = entry_free;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tail <= '0;
			cmt  <= '0;
			head <= '0;
			for (int i = 0; i < sq_depth; i++) begin
				entries[i].state <= entry_free;
			end
		end else begin
			tail    <= tail_next;
			cmt     <= cmt_next;
			head    <= head_next;
			entries <= entries_next;
		end
	end

	a_no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
		alloc[0].valid |-> !full);

	// the arbiter may only pick a committed head
	a_grant_committed: assert property (@(posedge clock) disable iff (reset)
		drain_grant |-> (head_entry.state == entry_committed));

endmodule : thread_store_queue

`default_nettype wire

// ==== store_queue.f ====
hdl/core_pkg.sv
hdl/lsq_pkg.sv
hdl/store_dispatch.sv
hdl/thread_store_queue.sv
hdl/store_drain_arbiter.sv
hdl/store_queue_top.sv
verification/store_queue_tb.sv

// ==== verification/store_queue_tb.sv ====
//////////////////////////////////////////////////
// testbench for the two-thread store queue
// applies a table of dispatch, commit and flush
// steps and checks every memory write against a
// per-thread queue model with thread 0 drain first
//////////////////////////////////////////////////

`default_nettype none

module store_queue_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import core_pkg::*;
	import lsq_pkg::*;

	localparam int sq_depth = 8;

	// one table row where bit k of each pair belongs to slot or port k
	typedef struct packed {
		logic [3:0]     test;
		logic [1:0]     dv, dth, cv, cth, mp, done;
		rob_idx_t [1:0] drob, crob;
	} step_t;

	typedef struct packed {
		word_t    addr;
		word_t    data;
		rob_idx_t rob;
	} store_rec_t;

	logic                  clock;
	logic                  reset;
	store_dispatch_t [1:0] dispatch;
	commit_port_t [1:0]    commit;
	logic [1:0]            mispredict;
	logic [1:0]            full;
	logic [1:0]            commit_done;
	mem_write_t            mem_write;

	step_t      steps [$];
	store_rec_t pend_q [2][$];   // dispatched but not yet committed
	store_rec_t cmtd_q [2][$];   // committed and waiting for the drain
	store_rec_t writes_q [$];    // granted with the write due next cycle
	integer     seed = 27;
	int         errors = 0;
	int         err_mark = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	int         writes_seen = 0;

	store_queue_top #(.sq_depth(sq_depth)) u_dut (
		.clock       (clock),
		.reset       (reset),
		.dispatch    (dispatch),
		.commit      (commit),
		.mispredict  (mispredict),
		.full        (full),
		.commit_done (commit_done),
		.mem_write   (mem_write)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic add_step(input int test, input logic [1:0] dv, input logic [1:0] dth,
		input int drob0, input int drob1, input logic [1:0] cv, input logic [1:0] cth,
		input int crob0, input int crob1, input logic [1:0] mp, input logic [1:0] done);
		step_t s;
		s.test    = 4'(test);
		s.dv      = dv;
		s.dth     = dth;
		s.drob[0] = rob_idx_t'(drob0);
		s.drob[1] = rob_idx_t'(drob1);
		s.cv      = cv;
		s.cth     = cth;
		s.crob[0] = rob_idx_t'(crob0);
		s.crob[1] = rob_idx_t'(crob1);
		s.mp      = mp;
		s.done    = done;
		steps.push_back(s);
	endtask

	// drive on the rising edge, check on the falling edge, then step the model
	task automatic apply_step(input step_t s);
		store_dispatch_t [1:0] d;
		commit_port_t [1:0]    c;
		store_rec_t            rec;
		logic [1:0]            exp_full;
		for (int k = 0; k < 2; k++) begin
			d[k].valid   = s.dv[k];
			d[k].thread  = thread_id_t'(s.dth[k]);
			d[k].base    = {$random(seed), $random(seed)};
			d[k].offset  = {$random(seed), $random(seed)};
			d[k].data    = {$random(seed), $random(seed)};
			d[k].rob_idx = s.drob[k];
			c[k].valid   = s.cv[k];
			c[k].thread  = thread_id_t'(s.cth[k]);
			c[k].rob_idx = s.crob[k];
		end
		@(posedge clock);
		dispatch   <= d;
		commit     <= c;
		mispredict <= s.mp;
		@(negedge clock);
		if (commit_done !== s.done) begin
			errors++;
			$display("ERR commit_done exp %h got %h in test %0d", s.done, commit_done, s.test);
		end
		for (int t = 0; t < 2; t++)   // fewer than two free entries
			exp_full[t] = (sq_depth - (pend_q[t].size() + cmtd_q[t].size())) < 2;
		if (full !== exp_full) begin
			errors++;
			$display("ERR full exp %h got %h in test %0d", exp_full, full, s.test);
		end
		if (mem_write.valid === 1'b1) begin
			if (writes_q.size() == 0) begin
				errors++;
				$display("unexpected memory write to %h in test %0d", mem_write.addr, s.test);
			end else begin
				rec = writes_q.pop_front();
				writes_seen++;
				if (mem_write.addr !== rec.addr) begin
					errors++;
					$display("ERR mem_write.addr exp %h got %h", rec.addr, mem_write.addr);
				end
				if (mem_write.data !== rec.data) begin
					errors++;
					$display("ERR mem_write.data exp %h got %h", rec.data, mem_write.data);
				end
			end
		end
		// grant uses the heads as they were at the start of the cycle
		if (cmtd_q[0].size() > 0)
			writes_q.push_back(cmtd_q[0].pop_front());
		else if (cmtd_q[1].size() > 0)
			writes_q.push_back(cmtd_q[1].pop_front());
		for (int p = 0; p < 2; p++) begin
			if (s.cv[p] && pend_q[s.cth[p]].size() > 0) begin   // oldest uncommitted only
				if (pend_q[s.cth[p]][0].rob == s.crob[p])
					cmtd_q[s.cth[p]].push_back(pend_q[s.cth[p]].pop_front());
			end
		end
		for (int t = 0; t < 2; t++) begin
			if (s.mp[t])
				pend_q[t].delete();
		end
		for (int k = 0; k < 2; k++) begin
			if (s.dv[k] && !s.mp[s.dth[k]]) begin
				rec.addr = d[k].base + d[k].offset;
				rec.data = d[k].data;
				rec.rob  = d[k].rob_idx;
				pend_q[s.dth[k]].push_back(rec);
			end
		end
	endtask

	// let committed stores drain, then a short quiet window
	task automatic finish_test(input int test);
		step_t idle;
		int    waited;
		int    bad;
		idle   = '0;
		waited = 0;
		while (writes_q.size() + cmtd_q[0].size() + cmtd_q[1].size() > 0 && waited < 40) begin
			apply_step(idle);
			waited++;
		end
		if (writes_q.size() + cmtd_q[0].size() + cmtd_q[1].size() > 0) begin
			errors++;
			$display("test %0d: timed out waiting for memory writes", test);
		end
		repeat (2) apply_step(idle);
		bad      = errors - err_mark;
		err_mark = errors;
		tests_run++;
		if (bad != 0)
			tests_failed++;
		$display("test %0d %s, %0d errors", test, (bad == 0) ? "passed" : "FAILED", bad);
	endtask

	initial begin
		dispatch   = '0;
		commit     = '0;
		mispredict = '0;
		reset      = 1'b1;

		//////////////////////////////////////////////////
		// test, dv, dth, drob0/1, cv, cth, crob0/1, mp, done
		//////////////////////////////////////////////////
		add_step(1, 2'b01, 2'b00, 1, 0, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(1, 2'b00, 2'b00, 0, 0, 2'b01, 2'b00, 1, 0, 2'b00, 2'b01);
		add_step(2, 2'b11, 2'b11, 2, 3, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(2, 2'b00, 2'b00, 0, 0, 2'b11, 2'b11, 2, 3, 2'b00, 2'b11);
		add_step(3, 2'b11, 2'b00, 5, 6, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(3, 2'b11, 2'b11, 4, 7, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(3, 2'b00, 2'b00, 0, 0, 2'b11, 2'b10, 5, 4, 2'b00, 2'b11);
		add_step(3, 2'b00, 2'b00, 0, 0, 2'b11, 2'b10, 6, 7, 2'b00, 2'b11);
		add_step(4, 2'b11, 2'b00, 8, 9, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(4, 2'b11, 2'b00, 10, 11, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(4, 2'b11, 2'b00, 12, 13, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(4, 2'b01, 2'b00, 14, 0, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);   // seventh entry
		add_step(4, 2'b00, 2'b00, 0, 0, 2'b01, 2'b00, 8, 0, 2'b00, 2'b01);
		add_step(4, 2'b00, 2'b00, 0, 0, 2'b11, 2'b00, 9, 10, 2'b00, 2'b11);
		add_step(4, 2'b00, 2'b00, 0, 0, 2'b11, 2'b00, 11, 12, 2'b00, 2'b11);
		add_step(4, 2'b00, 2'b00, 0, 0, 2'b11, 2'b00, 13, 14, 2'b00, 2'b11);
		add_step(5, 2'b11, 2'b11, 15, 16, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(5, 2'b01, 2'b00, 17, 0, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(5, 2'b00, 2'b00, 0, 0, 2'b01, 2'b01, 15, 0, 2'b00, 2'b01);
		add_step(5, 2'b01, 2'b01, 18, 0, 2'b00, 2'b00, 0, 0, 2'b10, 2'b00);   // flush thread 1
		add_step(5, 2'b00, 2'b00, 0, 0, 2'b11, 2'b01, 16, 17, 2'b00, 2'b10);
		add_step(5, 2'b00, 2'b00, 0, 0, 2'b01, 2'b01, 18, 0, 2'b00, 2'b00);
		add_step(6, 2'b01, 2'b00, 20, 0, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(6, 2'b00, 2'b00, 0, 0, 2'b01, 2'b00, 21, 0, 2'b00, 2'b00);
		add_step(6, 2'b00, 2'b00, 0, 0, 2'b10, 2'b00, 0, 22, 2'b00, 2'b00);
		add_step(6, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00, 0, 0, 2'b00, 2'b00);
		add_step(6, 2'b00, 2'b00, 0, 0, 2'b01, 2'b00, 20, 0, 2'b00, 2'b01);

		repeat (16) @(posedge clock);
		reset <= 1'b0;

		for (int i = 0; i < steps.size(); i++) begin
			apply_step(steps[i]);
			if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test)
				finish_test(int'(steps[i].test));
		end

		$display("tests %0d, failed %0d, writes checked %0d, errors %0d",
			tests_run, tests_failed, writes_seen, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule : store_queue_tb

`default_nettype wire
